//--- list.f
+incdir+.
udp_csum_pkg.sv
udp_beat_sum.sv
udp_csum_ctrl.sv
udp_payload_fifo.sv
udp_hdr_fifo.sv
udp_checksum_gen.sv
tb_udp_checksum_gen.sv

//--- Bender.yml
package:
  name: udp_checksum_gen

sources:
  - include_dirs:
      - .
    files:
      - udp_csum_pkg.sv
      - udp_beat_sum.sv
      - udp_csum_ctrl.sv
      - udp_payload_fifo.sv
      - udp_hdr_fifo.sv
      - udp_checksum_gen.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_udp_checksum_gen.sv

//--- tb_udp_checksum_gen.sv
`timescale 1ns/100ps
`include "udp_csum_consts.svh"

module tb_udp_checksum_gen import udp_csum_pkg::*; ();

    localparam int NUM_FRAMES = 30;
    localparam int MAX_BYTES  = 40;
    localparam int WAIT_LIMIT = 2000;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       s_hdr_valid, s_hdr_ready;
    ip_addr_t   s_src_ip, s_dst_ip;
    udp_port_t  s_src_port, s_dst_port;
    axis_data_t s_tdata;
    axis_keep_t s_tkeep;
    logic       s_tvalid, s_tlast, s_tready;
    logic       m_hdr_valid;
    logic       m_hdr_ready = 1'b0;
    ip_addr_t   m_src_ip, m_dst_ip;
    udp_port_t  m_src_port, m_dst_port;
    udp_len_t   m_udp_length;
    csum_t      m_udp_checksum;
    axis_data_t m_tdata;
    axis_keep_t m_tkeep;
    logic       m_tvalid, m_tlast;
    logic       m_tready = 1'b0;
    logic       busy;

    logic [15:0] lfsr_state = 16'd56;
    int          gap_mode   = 0;
    int          hdr_seen   = 0;
    int          beat_seen  = 0;
    int          total_beats = 0;

    // frame table, filled once at time zero
    ip_addr_t               frm_src_ip [NUM_FRAMES];
    ip_addr_t               frm_dst_ip [NUM_FRAMES];
    udp_port_t              frm_src_port [NUM_FRAMES];
    udp_port_t              frm_dst_port [NUM_FRAMES];
    int                     frm_len [NUM_FRAMES];
    logic [8*MAX_BYTES-1:0] frm_payload [NUM_FRAMES];

    ip_addr_t   exp_src_ip[$], exp_dst_ip[$];
    udp_port_t  exp_src_port[$], exp_dst_port[$];
    udp_len_t   exp_len[$];
    csum_t      exp_csum[$];
    axis_data_t exp_data[$];
    axis_keep_t exp_keep[$];
    logic       exp_last[$];

    always #10 clk = ~clk;

    udp_checksum_gen UUT (
        .clk(clk), .rst(rst),
        .s_hdr_valid(s_hdr_valid), .s_hdr_ready(s_hdr_ready),
        .s_src_ip(s_src_ip), .s_dst_ip(s_dst_ip),
        .s_src_port(s_src_port), .s_dst_port(s_dst_port),
        .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid),
        .s_tlast(s_tlast), .s_tready(s_tready),
        .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready),
        .m_src_ip(m_src_ip), .m_dst_ip(m_dst_ip),
        .m_src_port(m_src_port), .m_dst_port(m_dst_port),
        .m_udp_length(m_udp_length), .m_udp_checksum(m_udp_checksum),
        .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid),
        .m_tlast(m_tlast), .m_tready(m_tready),
        .busy(busy)
    );

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic axis_keep_t keep_mask(input int remaining);
        if (remaining >= 8) begin
            return 8'hff;
        end
        return (8'h01 << remaining) - 8'h01;
    endfunction

    // pseudo-header, udp header and payload, ones' complement
    function automatic csum_t ref_checksum(input ip_addr_t src_ip, input ip_addr_t dst_ip,
            input udp_port_t src_port, input udp_port_t dst_port,
            input logic [8*MAX_BYTES-1:0] payload, input int nbytes);
        logic [31:0] sum;
        logic [15:0] udp_len;
        logic [7:0]  lo_byte;
        int          k;
        udp_len = 16'(nbytes + `UDP_HDR_LEN);
        sum = src_ip[31:16] + src_ip[15:0] + dst_ip[31:16] + dst_ip[15:0] + `UDP_PROTO
            + udp_len + udp_len + src_port + dst_port;
        for (k = 0; k < nbytes; k += 2) begin
            // odd tail gets a zero low byte
            lo_byte = (k + 1 < nbytes) ? payload[(k+1)*8 +: 8] : 8'h00;
            sum = sum + {payload[k*8 +: 8], lo_byte};
        end
        while (sum[31:16] != 16'h0) begin
            sum = sum[15:0] + sum[31:16];
        end
        return ~sum[15:0];
    endfunction

    task automatic end_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        end_with_failure();
    endtask

    task automatic check_addr(input string name, input ip_addr_t got, input ip_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_port(input string name, input udp_port_t got, input udp_port_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_len(input string name, input udp_len_t got, input udp_len_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_csum(input string name, input csum_t got, input csum_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_data(input string name, input axis_data_t got, input axis_data_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_keep(input string name, input axis_keep_t got, input axis_keep_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic build_frames();
        int f;
        int k;
        int b;
        int beats;
        for (f = 0; f < NUM_FRAMES; f++) begin
            frm_src_ip[f]   = rand_bits(32);
            frm_dst_ip[f]   = rand_bits(32);
            frm_src_port[f] = udp_port_t'(rand_bits(16));
            frm_dst_port[f] = udp_port_t'(rand_bits(16));
            // first frames pin full beats, odd tails and the extremes
            case (f)
                0:       frm_len[f] = 16;
                1:       frm_len[f] = 13;
                2:       frm_len[f] = 7;
                3:       frm_len[f] = 1;
                4:       frm_len[f] = 40;
                default: frm_len[f] = rand_bits(6) % 40 + 1;
            endcase
            // bytes past the length are garbage and must still pass through
            for (k = 0; k < MAX_BYTES; k++) begin
                frm_payload[f][k*8 +: 8] = rand_bits(8);
            end
            exp_src_ip.push_back(frm_src_ip[f]);
            exp_dst_ip.push_back(frm_dst_ip[f]);
            exp_src_port.push_back(frm_src_port[f]);
            exp_dst_port.push_back(frm_dst_port[f]);
            exp_len.push_back(udp_len_t'(frm_len[f] + `UDP_HDR_LEN));
            exp_csum.push_back(ref_checksum(frm_src_ip[f], frm_dst_ip[f], frm_src_port[f],
                                            frm_dst_port[f], frm_payload[f], frm_len[f]));
            beats = (frm_len[f] + 7) / 8;
            for (b = 0; b < beats; b++) begin
                exp_data.push_back(frm_payload[f][b*64 +: 64]);
                exp_keep.push_back(keep_mask(frm_len[f] - 8 * b));
                exp_last.push_back(b == beats - 1);
            end
            total_beats += beats;
        end
    endtask

    task automatic send_frame(input int f);
        int b;
        int n;
        int beats;
        beats = (frm_len[f] + 7) / 8;
        @(posedge clk);
        s_hdr_valid <= 1'b1;
        s_src_ip    <= frm_src_ip[f];
        s_dst_ip    <= frm_dst_ip[f];
        s_src_port  <= frm_src_port[f];
        s_dst_port  <= frm_dst_port[f];
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) report_timeout("s_hdr_ready");
        end while (!s_hdr_ready);
        // no frame in progress when a header is taken
        check_bit("busy", busy, 1'b0);
        for (b = 0; b < beats; b++) begin
            @(posedge clk);
            s_hdr_valid <= 1'b0;
            s_tvalid    <= 1'b1;
            s_tdata     <= frm_payload[f][b*64 +: 64];
            s_tkeep     <= keep_mask(frm_len[f] - 8 * b);
            s_tlast     <= (b == beats - 1);
            n = 0;
            do begin
                @(negedge clk);
                n++;
                if (n > WAIT_LIMIT) report_timeout("s_tready");
                check_bit("busy", busy, 1'b1);
            end while (!s_tready);
        end
        @(posedge clk);
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
        // two finish cycles keep busy up, then the sum is done
        @(negedge clk);
        check_bit("busy", busy, 1'b1);
        @(negedge clk);
        check_bit("busy", busy, 1'b1);
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
    endtask

    task automatic wait_outputs(input int frames, input int beats, input int limit);
        int n;
        n = 0;
        while (hdr_seen < frames || beat_seen < beats) begin
            @(posedge clk);
            n++;
            if (n > limit) report_timeout("output headers and payload beats");
        end
    endtask

    // output ready patterns
    always @(posedge clk) begin
        if (rst) begin
            m_hdr_ready <= 1'b0;
            m_tready    <= 1'b0;
        end else if (gap_mode == 0) begin
            m_hdr_ready <= 1'b1;
            m_tready    <= 1'b1;
        end else if (gap_mode == 1) begin
            m_hdr_ready <= rand_bits(2) != 0;
            m_tready    <= rand_bits(2) != 0;
        end else begin
            // slow header drain lets the header FIFO fill up
            m_hdr_ready <= rand_bits(4) == 0;
            m_tready    <= rand_bits(2) == 0;
        end
    end

    always @(negedge clk) begin
        if (!rst && m_hdr_valid && m_hdr_ready) begin
            if (exp_src_ip.size() == 0) begin
                $display("output header appeared with no frame outstanding");
                end_with_failure();
            end else begin
                check_addr("m_src_ip", m_src_ip, exp_src_ip.pop_front());
                check_addr("m_dst_ip", m_dst_ip, exp_dst_ip.pop_front());
                check_port("m_src_port", m_src_port, exp_src_port.pop_front());
                check_port("m_dst_port", m_dst_port, exp_dst_port.pop_front());
                check_len("m_udp_length", m_udp_length, exp_len.pop_front());
                check_csum("m_udp_checksum", m_udp_checksum, exp_csum.pop_front());
                hdr_seen++;
            end
        end
        if (!rst && m_tvalid && m_tready) begin
            if (exp_data.size() == 0) begin
                $display("output payload beat appeared with no beat outstanding");
                end_with_failure();
            end else begin
                check_data("m_tdata", m_tdata, exp_data.pop_front());
                check_keep("m_tkeep", m_tkeep, exp_keep.pop_front());
                check_bit("m_tlast", m_tlast, exp_last.pop_front());
                beat_seen++;
            end
        end
    end

    initial begin
        int f;
        int n;
        s_hdr_valid <= 1'b0;
        s_src_ip    <= '0;
        s_dst_ip    <= '0;
        s_src_port  <= '0;
        s_dst_port  <= '0;
        s_tdata     <= '0;
        s_tkeep     <= '0;
        s_tvalid    <= 1'b0;
        s_tlast     <= 1'b0;
        build_frames();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // last edge still saw reset
        @(negedge clk);
        check_bit("m_hdr_valid", m_hdr_valid, 1'b0);
        check_bit("m_tvalid", m_tvalid, 1'b0);
        check_bit("s_hdr_ready", s_hdr_ready, 1'b0);
        check_bit("s_tready", s_tready, 1'b0);
        check_bit("busy", busy, 1'b0);
        n = 0;
        while (!s_hdr_ready) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) report_timeout("s_hdr_ready after reset");
        end

        // single full-beat frame on its own
        send_frame(0);
        wait_outputs(1, (frm_len[0] + 7) / 8, WAIT_LIMIT);
        for (f = 1; f < 5; f++) begin
            send_frame(f);
        end

        @(posedge clk);
        gap_mode <= 1;
        for (f = 5; f < 20; f++) begin
            send_frame(f);
        end
        @(posedge clk);
        gap_mode <= 2;
        for (f = 20; f < NUM_FRAMES; f++) begin
            send_frame(f);
        end
        @(posedge clk);
        gap_mode <= 1;
        wait_outputs(NUM_FRAMES, total_beats, 10 * WAIT_LIMIT);

        repeat (4) @(negedge clk);
        check_bit("m_hdr_valid", m_hdr_valid, 1'b0);
        check_bit("m_tvalid", m_tvalid, 1'b0);
        check_bit("busy", busy, 1'b0);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- udp_checksum_gen.sv
`timescale 1ns/100ps

module udp_checksum_gen import udp_csum_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // header in
    input  logic       s_hdr_valid,
    output logic       s_hdr_ready,
    input  ip_addr_t   s_src_ip,
    input  ip_addr_t   s_dst_ip,
    input  udp_port_t  s_src_port,
    input  udp_port_t  s_dst_port,
    // payload in
    input  axis_data_t s_tdata,
    input  axis_keep_t s_tkeep,
    input  logic       s_tvalid,
    input  logic       s_tlast,
    output logic       s_tready,
    // header out
    output logic       m_hdr_valid,
    input  logic       m_hdr_ready,
    output ip_addr_t   m_src_ip,
    output ip_addr_t   m_dst_ip,
    output udp_port_t  m_src_port,
    output udp_port_t  m_dst_port,
    output udp_len_t   m_udp_length,
    output csum_t      m_udp_checksum,
    // payload out
    output axis_data_t m_tdata,
    output axis_keep_t m_tkeep,
    output logic       m_tvalid,
    output logic       m_tlast,
    input  logic       m_tready,
    output logic       busy
);

    csum_part_t lane_lo;
    csum_part_t lane_hi;
    byte_cnt_t  byte_cnt;
    logic       payload_full;
    logic       payload_push;
    logic       hdr_full;
    logic       hdr_wr_en;
    ip_addr_t   hdr_src_ip;
    ip_addr_t   hdr_dst_ip;
    udp_port_t  hdr_src_port;
    udp_port_t  hdr_dst_port;
    udp_len_t   hdr_length;
    csum_t      hdr_checksum;

    udp_beat_sum u_beat_sum (
        .tdata    (s_tdata),
        .tkeep    (s_tkeep),
        .lane_lo  (lane_lo),
        .lane_hi  (lane_hi),
        .byte_cnt (byte_cnt)
    );

    udp_csum_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .s_hdr_valid  (s_hdr_valid),
        .s_hdr_ready  (s_hdr_ready),
        .s_src_ip     (s_src_ip),
        .s_dst_ip     (s_dst_ip),
        .s_src_port   (s_src_port),
        .s_dst_port   (s_dst_port),
        .s_tvalid     (s_tvalid),
        .s_tlast      (s_tlast),
        .s_tready     (s_tready),
        .payload_push (payload_push),
        .lane_lo      (lane_lo),
        .lane_hi      (lane_hi),
        .byte_cnt     (byte_cnt),
        .payload_full (payload_full),
        .hdr_full     (hdr_full),
        .hdr_wr_en    (hdr_wr_en),
        .hdr_src_ip   (hdr_src_ip),
        .hdr_dst_ip   (hdr_dst_ip),
        .hdr_src_port (hdr_src_port),
        .hdr_dst_port (hdr_dst_port),
        .hdr_length   (hdr_length),
        .hdr_checksum (hdr_checksum),
        .busy         (busy)
    );

    // payload is stored unchanged and leaves ahead of its header
    udp_payload_fifo u_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (payload_push),
        .in_data  (s_tdata),
        .in_keep  (s_tkeep),
        .in_last  (s_tlast),
        .full     (payload_full),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tready (m_tready)
    );

    udp_hdr_fifo u_hdr_fifo (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (hdr_wr_en),
        .src_ip         (hdr_src_ip),
        .dst_ip         (hdr_dst_ip),
        .src_port       (hdr_src_port),
        .dst_port       (hdr_dst_port),
        .udp_length     (hdr_length),
        .udp_checksum   (hdr_checksum),
        .full           (hdr_full),
        .m_hdr_valid    (m_hdr_valid),
        .m_hdr_ready    (m_hdr_ready),
        .m_src_ip       (m_src_ip),
        .m_dst_ip       (m_dst_ip),
        .m_src_port     (m_src_port),
        .m_dst_port     (m_dst_port),
        .m_udp_length   (m_udp_length),
        .m_udp_checksum (m_udp_checksum)
    );

endmodule

//--- udp_hdr_fifo.sv
`timescale 1ns/100ps
`include "udp_csum_consts.svh"

module udp_hdr_fifo import udp_csum_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  ip_addr_t  src_ip,
    input  ip_addr_t  dst_ip,
    input  udp_port_t src_port,
    input  udp_port_t dst_port,
    input  udp_len_t  udp_length,
    input  csum_t     udp_checksum,
    output logic      full,
    output logic      m_hdr_valid,
    input  logic      m_hdr_ready,
    output ip_addr_t  m_src_ip,
    output ip_addr_t  m_dst_ip,
    output udp_port_t m_src_port,
    output udp_port_t m_dst_port,
    output udp_len_t  m_udp_length,
    output csum_t     m_udp_checksum
);

    localparam int AW    = `UDP_HDR_FIFO_AW;
    localparam int DEPTH = 1 << AW;
    localparam int HDR_W = 2 * $bits(ip_addr_t) + 2 * $bits(udp_port_t)
                         + $bits(udp_len_t) + $bits(csum_t);

    logic [HDR_W-1:0] mem [0:DEPTH-1];
    logic [HDR_W-1:0] wr_word;
    logic [HDR_W-1:0] out_reg;
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;
    logic             empty;
    logic             rd_en;

    assign wr_word = {src_ip, dst_ip, src_port, dst_port, udp_length, udp_checksum};

    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = wr_ptr == rd_ptr;

    // output register loads when free or when its header is taken
    assign rd_en = !empty && (m_hdr_ready || !m_hdr_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr      <= rd_ptr + 1'b1;
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
        end

        if (wr_en && !full) begin
            mem[wr_ptr[AW-1:0]] <= wr_word;
        end
        if (rd_en) begin
            out_reg <= mem[rd_ptr[AW-1:0]];
        end
    end

    // unpack in the same field order as wr_word
    assign {m_src_ip, m_dst_ip, m_src_port, m_dst_port, m_udp_length, m_udp_checksum} = out_reg;

endmodule

//--- udp_payload_fifo.sv
`timescale 1ns/100ps
`include "udp_csum_consts.svh"

module udp_payload_fifo import udp_csum_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  axis_data_t in_data,
    input  axis_keep_t in_keep,
    input  logic       in_last,
    output logic       full,
    output axis_data_t m_tdata,
    output axis_keep_t m_tkeep,
    output logic       m_tvalid,
    output logic       m_tlast,
    input  logic       m_tready
);

    localparam int AW    = `UDP_PAYLOAD_FIFO_AW;
    localparam int DEPTH = 1 << AW;
    localparam int ENT_W = `UDP_DATA_W + `UDP_KEEP_W + 1;

    logic [ENT_W-1:0] mem [0:DEPTH-1];
    logic [ENT_W-1:0] out_reg;
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;
    logic             empty;
    logic             rd_en;

    // extra pointer bit tells full from empty
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = wr_ptr == rd_ptr;

    // refill the output register when it is free or being taken
    assign rd_en = !empty && (m_tready || !m_tvalid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            m_tvalid <= 1'b0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr   <= rd_ptr + 1'b1;
                m_tvalid <= 1'b1;
            end else if (m_tready) begin
                m_tvalid <= 1'b0;
            end
        end

        if (push && !full) begin
            mem[wr_ptr[AW-1:0]] <= {in_last, in_keep, in_data};
        end
        if (rd_en) begin
            out_reg <= mem[rd_ptr[AW-1:0]];
        end
    end

    assign {m_tlast, m_tkeep, m_tdata} = out_reg;

endmodule

//--- udp_csum_ctrl.sv
`timescale 1ns/100ps
`include "udp_csum_consts.svh"

module udp_csum_ctrl import udp_csum_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       s_hdr_valid,
    output logic       s_hdr_ready,
    input  ip_addr_t   s_src_ip,
    input  ip_addr_t   s_dst_ip,
    input  udp_port_t  s_src_port,
    input  udp_port_t  s_dst_port,
    input  logic       s_tvalid,
    input  logic       s_tlast,
    output logic       s_tready,
    output logic       payload_push,
    input  csum_part_t lane_lo,
    input  csum_part_t lane_hi,
    input  byte_cnt_t  byte_cnt,
    input  logic       payload_full,
    input  logic       hdr_full,
    output logic       hdr_wr_en,
    output ip_addr_t   hdr_src_ip,
    output ip_addr_t   hdr_dst_ip,
    output udp_port_t  hdr_src_port,
    output udp_port_t  hdr_dst_port,
    output udp_len_t   hdr_length,
    output csum_t      hdr_checksum,
    output logic       busy
);

    csum_state_t state_reg, state_next;
    logic        hdr_ready_next;
    logic        hdr_wr_en_next;
    logic        store_hdr;
    logic        beat_take;

    ip_addr_t    src_ip_reg;
    ip_addr_t    dst_ip_reg;
    udp_port_t   src_port_reg;
    udp_port_t   dst_port_reg;

    udp_len_t    len_reg, len_next;
    csum_acc_t   acc_reg, acc_next;
    csum_part_t  part_a_reg, part_a_next;
    csum_part_t  part_b_reg, part_b_next;
    csum_part_t  fold;
    csum_t       csum_final;
    csum_t       csum_reg;

    assign s_tready     = (state_reg == sum_payload) && !payload_full;
    assign beat_take    = s_tvalid && s_tready;
    assign payload_push = beat_take;
    assign store_hdr    = s_hdr_valid && s_hdr_ready;

    // end-around carry, a second fold catches the carry of the first
    assign fold       = acc_reg[15:0] + acc_reg[31:16];
    assign csum_final = ~(fold[15:0] + fold[16]);

    always_comb begin
        state_next     = state_reg;
        hdr_ready_next = 1'b0;
        hdr_wr_en_next = 1'b0;
        acc_next       = acc_reg;
        part_a_next    = part_a_reg;
        part_b_next    = part_b_reg;
        len_next       = len_reg;

        case (state_reg)
            idle: begin
                // hold off one cycle after a write so full is up to date
                hdr_ready_next = !hdr_full && !hdr_wr_en;
                if (store_hdr) begin
                    hdr_ready_next = 1'b0;
                    // protocol plus the header part of the length, twice
                    acc_next       = `UDP_PROTO + 2 * `UDP_HDR_LEN;
                    part_a_next    = s_src_ip[31:16];
                    part_b_next    = s_src_ip[15:0];
                    state_next     = sum_header;
                end
            end
            sum_header: begin
                acc_next    = acc_reg + part_a_reg + part_b_reg;
                part_a_next = dst_ip_reg[31:16] + dst_ip_reg[15:0];
                part_b_next = src_port_reg + dst_port_reg;
                len_next    = `UDP_HDR_LEN;
                state_next  = sum_payload;
            end
            sum_payload: begin
                if (beat_take) begin
                    // payload bytes count twice, pseudo-header and udp length
                    acc_next    = acc_reg + part_a_reg + part_b_reg + {byte_cnt, 1'b0};
                    part_a_next = lane_lo;
                    part_b_next = lane_hi;
                    len_next    = len_reg + byte_cnt;
                    if (s_tlast) begin
                        state_next = finish_1;
                    end
                end
            end
            finish_1: begin
                // drain the lane pipeline
                acc_next   = acc_reg + part_a_reg + part_b_reg;
                state_next = finish_2;
            end
            finish_2: begin
                hdr_wr_en_next = 1'b1;
                state_next     = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg   <= idle;
            s_hdr_ready <= 1'b0;
            hdr_wr_en   <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state_reg   <= state_next;
            s_hdr_ready <= hdr_ready_next;
            hdr_wr_en   <= hdr_wr_en_next;
            busy        <= state_next != idle;
        end

        acc_reg    <= acc_next;
        part_a_reg <= part_a_next;
        part_b_reg <= part_b_next;
        len_reg    <= len_next;

        if (store_hdr) begin
            src_ip_reg   <= s_src_ip;
            dst_ip_reg   <= s_dst_ip;
            src_port_reg <= s_src_port;
            dst_port_reg <= s_dst_port;
        end

        if (state_reg == finish_2) begin
            csum_reg <= csum_final;
        end
    end

    assign hdr_src_ip   = src_ip_reg;
    assign hdr_dst_ip   = dst_ip_reg;
    assign hdr_src_port = src_port_reg;
    assign hdr_dst_port = dst_port_reg;
    assign hdr_length   = len_reg;
    assign hdr_checksum = csum_reg;

endmodule

//--- udp_beat_sum.sv
`timescale 1ns/100ps
`include "udp_csum_consts.svh"

module udp_beat_sum import udp_csum_pkg::*; (
    input  axis_data_t tdata,
    input  axis_keep_t tkeep,
    output csum_part_t lane_lo,
    output csum_part_t lane_hi,
    output byte_cnt_t  byte_cnt
);

    localparam int LANE_BYTES = `UDP_KEEP_W / 2;

    // even bytes are the high half of a 16-bit word
    always_comb begin
        lane_lo = '0;
        lane_hi = '0;
        for (int i = 0; i < LANE_BYTES; i++) begin
            if (tkeep[i]) begin
                if (i % 2 == 0) begin
                    lane_lo = lane_lo + {tdata[i*8 +: 8], 8'h00};
                end else begin
                    lane_lo = lane_lo + {8'h00, tdata[i*8 +: 8]};
                end
            end
        end
        for (int i = LANE_BYTES; i < `UDP_KEEP_W; i++) begin
            if (tkeep[i]) begin
                if (i % 2 == 0) begin
                    lane_hi = lane_hi + {tdata[i*8 +: 8], 8'h00};
                end else begin
                    lane_hi = lane_hi + {8'h00, tdata[i*8 +: 8]};
                end
            end
        end
    end

    // keep is contiguous from bit 0, so counting set bits gives the length
    always_comb begin
        byte_cnt = '0;
        for (int i = 0; i < `UDP_KEEP_W; i++) begin
            byte_cnt = byte_cnt + byte_cnt_t'(tkeep[i]);
        end
    end

endmodule

//--- udp_csum_pkg.sv
package udp_csum_pkg;

    // header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // checksum arithmetic
    typedef logic [15:0] csum_t;
    typedef logic [31:0] csum_acc_t;
    typedef logic [16:0] csum_part_t;

    // payload stream
    typedef logic [63:0] axis_data_t;
    typedef logic [7:0]  axis_keep_t;
    typedef logic [3:0]  byte_cnt_t;

    typedef enum logic [2:0] {
        idle,
        sum_header,
        sum_payload,
        finish_1,
        finish_2
    } csum_state_t;

endpackage

//--- udp_csum_consts.svh
`ifndef UDP_CSUM_CONSTS_SVH
`define UDP_CSUM_CONSTS_SVH

// payload FIFO holds 2**8 beats
`define UDP_PAYLOAD_FIFO_AW 8

// header FIFO holds 2**3 finished headers
`define UDP_HDR_FIFO_AW 3

// payload stream geometry
`define UDP_DATA_W 64
`define UDP_KEEP_W 8

// udp header bytes, also the start value of the length counter
`define UDP_HDR_LEN 8

// ip protocol number for udp, zero padded in the pseudo-header
`define UDP_PROTO 17

`endif
